// File: Makefile
TOP = tb_chip_push

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim +verilator+error+limit+100)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: src/apb_regs.sv
// APB register block that holds length and sync, loads the chip buffer and qualifies fire requests
`timescale 1ns/1ns

module apb_regs #(
	parameter int buf_depth = 256,
	parameter int addr_w    = 8
) (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	// apb slave
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [addr_w-1:0]           paddr,
	input  logic [chip_pkg::word_w-1:0] pwdata,
	output logic [chip_pkg::word_w-1:0] prdata,
	// chip buffer
	output logic                        buf_wr,
	output logic [chip_pkg::word_w-1:0] buf_wdata,
	input  logic [$clog2(buf_depth):0]  level,
	// push stage
	output logic                        fire,
	output logic [chip_pkg::len_w-1:0]  chip_len,
	output logic [chip_pkg::word_w-1:0] sync_word,
	input  logic                        busy,
	input  logic                        push_done,
	output logic                        irq_done
);

	localparam int fill_w = chip_pkg::word_w - chip_pkg::stat_fill;
	localparam int cmp_w  = chip_pkg::len_w + 1;

	logic                        wr_en;
	logic                        rd_en;
	logic                        sel_ctrl;
	logic                        sel_len;
	logic                        sel_sync;
	logic                        sel_data;
	logic                        sel_stat;
	logic                        fire_req;
	logic                        fire_bad;
	logic                        done_flag;
	logic                        err_flag;
	logic [chip_pkg::word_w-1:0] status;

	// zero wait states
	assign wr_en  = psel & penable & pwrite;
	assign rd_en  = psel & ~pwrite;

	// address decode
	assign sel_ctrl = (paddr == addr_w'(chip_pkg::ctrl_addr));
	assign sel_len  = (paddr == addr_w'(chip_pkg::len_addr));
	assign sel_sync = (paddr == addr_w'(chip_pkg::sync_addr));
	assign sel_data = (paddr == addr_w'(chip_pkg::data_addr));
	assign sel_stat = (paddr == addr_w'(chip_pkg::status_addr));

	assign buf_wr    = wr_en & sel_data;
	assign buf_wdata = pwdata;

	// --------------------
	// fire check
	// --------------------
	assign fire_req = wr_en & sel_ctrl & pwdata[0] & ~busy;
	// zero length, or not enough words buffered
	assign fire_bad = (chip_len == '0) || (cmp_w'(level) < cmp_w'(chip_len));
	assign fire     = fire_req & ~fire_bad;

	assign irq_done = push_done;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			chip_len  <= '0;
			sync_word <= '0;
		end else if (wr_en) begin
			if (sel_len)
				chip_len <= pwdata[chip_pkg::len_w-1:0];
			if (sel_sync)
				sync_word <= pwdata;
		end
	end

	// sticky flags cleared by each new fire request
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			done_flag <= 1'b0;
			err_flag  <= 1'b0;
		end else if (fire_req) begin
			done_flag <= 1'b0;
			err_flag  <= fire_bad;
		end else if (push_done) begin
			done_flag <= 1'b1;
		end
	end

	// --------------------
	// read back
	// --------------------
	always_comb begin
		status = '0;
		status[chip_pkg::stat_busy] = busy;
		status[chip_pkg::stat_done] = done_flag;
		status[chip_pkg::stat_err]  = err_flag;
		status[chip_pkg::word_w-1:chip_pkg::stat_fill] = fill_w'(level);
	end

	always_comb begin
		prdata = '0;
		if (rd_en) begin
			if (sel_stat)
				prdata = status;
			else if (sel_len)
				prdata = chip_pkg::word_w'(chip_len);
			else if (sel_sync)
				prdata = sync_word;
		end
	end

endmodule

// File: src/chip_buf.sv
// show-ahead FIFO of chip data words; head word is visible without a read, level counts entries
`timescale 1ns/1ns

module chip_buf #(
	parameter int buf_depth = 256
) (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        wr,
	input  logic [chip_pkg::word_w-1:0] wdata,
	input  logic                        rdreq,
	output logic [chip_pkg::word_w-1:0] q,
	output logic [$clog2(buf_depth):0]  level
);

	localparam int ptr_w = $clog2(buf_depth);

	logic [chip_pkg::word_w-1:0] mem [buf_depth];
	logic [ptr_w-1:0]            wr_ptr;
	logic [ptr_w-1:0]            rd_ptr;
	logic                        full;
	logic                        empty;
	logic                        do_wr;
	logic                        do_rd;

	assign full  = (level == (ptr_w + 1)'(buf_depth));
	assign empty = (level == '0);

	// writes to a full buffer are lost
	assign do_wr = wr & ~full;
	assign do_rd = rdreq & ~empty;

	always_ff @(posedge clk_sys) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	// --------------------
	// pointers and level
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// head word
	assign q = empty ? '0 : mem[rd_ptr];

endmodule

// File: src/chip_if.sv
// one-word link from the push FSM to the transmit stage, one word in flight at a time
`timescale 1ns/1ns

interface chip_if;

	// word and its strobe
	logic [chip_pkg::word_w-1:0] d;
	logic                        vld;
	// final data word of the packet
	logic                        last;
	// word accepted downstream
	logic                        done;

	modport src (output d, output vld, output last, input done);

	modport sink (input d, input vld, input last, output done);

endinterface

// File: src/chip_pkg.sv
// shared widths, APB register map and push FSM states, used by every RTL block of the chip pusher
package chip_pkg;

	// data path widths
	localparam int word_w = 16;
	localparam int len_w  = 12;

	// --------------------
	// register offsets
	// --------------------
	localparam int ctrl_addr   = 'h00;
	localparam int len_addr    = 'h04;
	localparam int sync_addr   = 'h08;
	localparam int data_addr   = 'h0C;
	localparam int status_addr = 'h10;

	// status register fields
	localparam int stat_busy = 0;
	localparam int stat_done = 1;
	localparam int stat_err  = 2;
	// fill level sits in the upper bits
	localparam int stat_fill = 4;

	// --------------------
	// push FSM
	// --------------------
	typedef enum logic [2:0] {
		idle,
		head_fire,
		head_wait,
		data_fire,
		data_wait,
		data_check,
		done
	} push_state_t;

endpackage

// File: src/chip_push_top.sv
// chip pusher top level: APB registers, chip buffer, push FSM and stream output on plain ports
`timescale 1ns/1ns

module chip_push_top #(
	parameter int buf_depth = 256,
	parameter int addr_w    = 8
) (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	// apb slave
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [addr_w-1:0]           paddr,
	input  logic [chip_pkg::word_w-1:0] pwdata,
	output logic [chip_pkg::word_w-1:0] prdata,
	// stream out
	output logic [chip_pkg::word_w-1:0] tx_data,
	output logic                        tx_valid,
	output logic                        tx_last,
	input  logic                        tx_ready,
	// end of packet
	output logic                        irq_done
);

	logic                        buf_wr;
	logic [chip_pkg::word_w-1:0] buf_wdata;
	logic [$clog2(buf_depth):0]  level;
	logic                        buf_rdreq;
	logic [chip_pkg::word_w-1:0] buf_q;
	logic                        fire;
	logic [chip_pkg::len_w-1:0]  chip_len;
	logic [chip_pkg::word_w-1:0] sync_word;
	logic                        busy;
	logic                        push_done;

	chip_if cif ();

	apb_regs #(.buf_depth(buf_depth), .addr_w(addr_w)) u_regs (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.buf_wr(buf_wr), .buf_wdata(buf_wdata), .level(level),
		.fire(fire), .chip_len(chip_len), .sync_word(sync_word),
		.busy(busy), .push_done(push_done), .irq_done(irq_done)
	);

	chip_buf #(.buf_depth(buf_depth)) u_buf (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.wr(buf_wr), .wdata(buf_wdata),
		.rdreq(buf_rdreq), .q(buf_q), .level(level)
	);

	pchip_push u_push (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.fire(fire), .chip_len(chip_len), .sync_word(sync_word),
		.busy(busy), .push_done(push_done),
		.buf_rdreq(buf_rdreq), .buf_q(buf_q), .cif(cif)
	);

	pkt_tx u_tx (
		.clk_sys(clk_sys), .rst_n(rst_n), .cif(cif),
		.tx_data(tx_data), .tx_valid(tx_valid),
		.tx_last(tx_last), .tx_ready(tx_ready)
	);

endmodule

// File: src/pchip_push.sv
// push FSM: sends sync, length and sequence header words, then the buffered data words
`timescale 1ns/1ns

module pchip_push (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	// control
	input  logic                        fire,
	input  logic [chip_pkg::len_w-1:0]  chip_len,
	input  logic [chip_pkg::word_w-1:0] sync_word,
	output logic                        busy,
	output logic                        push_done,
	// chip buffer
	output logic                        buf_rdreq,
	input  logic [chip_pkg::word_w-1:0] buf_q,
	// word link to transmit stage
	chip_if.src                         cif
);

	chip_pkg::push_state_t       state;
	logic [1:0]                  head_idx;
	logic [chip_pkg::len_w-1:0]  data_cnt;
	logic [chip_pkg::len_w-1:0]  len_q;
	logic [chip_pkg::word_w-1:0] sync_q;
	logic [chip_pkg::word_w-1:0] seq_num;
	logic [chip_pkg::word_w-1:0] head_word;
	logic                        finish;

	// --------------------
	// main FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= chip_pkg::idle;
		end else begin
			case (state)
				chip_pkg::idle:
					if (fire)
						state <= chip_pkg::head_fire;
				chip_pkg::head_fire:
					state <= chip_pkg::head_wait;
				chip_pkg::head_wait:
					if (cif.done)
						state <= (head_idx == 2'd2) ? chip_pkg::data_fire : chip_pkg::head_fire;
				chip_pkg::data_fire:
					state <= chip_pkg::data_wait;
				chip_pkg::data_wait:
					if (cif.done)
						state <= chip_pkg::data_check;
				chip_pkg::data_check:
					state <= finish ? chip_pkg::done : chip_pkg::data_fire;
				chip_pkg::done:
					state <= chip_pkg::idle;
				default:
					state <= chip_pkg::idle;
			endcase
		end
	end

	// header index, data count, packet sequence
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			head_idx <= '0;
			data_cnt <= '0;
			seq_num  <= '0;
		end else begin
			if (state == chip_pkg::idle) begin
				head_idx <= '0;
				data_cnt <= '0;
			end
			if (state == chip_pkg::head_wait && cif.done)
				head_idx <= head_idx + 1'b1;
			if (state == chip_pkg::data_fire)
				data_cnt <= data_cnt + 1'b1;
			if (state == chip_pkg::done)
				seq_num <= seq_num + 1'b1;
		end
	end

	// snapshot so later APB writes do not disturb a running packet
	always_ff @(posedge clk_sys) begin
		if (state == chip_pkg::idle && fire) begin
			len_q  <= chip_len;
			sync_q <= sync_word;
		end
	end

	assign finish = (data_cnt == len_q);

	always_comb begin
		case (head_idx)
			2'd0:    head_word = sync_q;
			2'd1:    head_word = chip_pkg::word_w'(len_q);
			default: head_word = seq_num;
		endcase
	end

	// --------------------
	// word out
	// --------------------
	assign cif.vld  = (state == chip_pkg::head_fire) || (state == chip_pkg::data_fire);
	assign cif.d    = (state == chip_pkg::head_fire) ? head_word : buf_q;
	assign cif.last = (state == chip_pkg::data_fire) && ((data_cnt + 1'b1) == len_q);

	// pop only after the word has gone out
	assign buf_rdreq = (state == chip_pkg::data_check);
	assign busy      = (state != chip_pkg::idle);
	assign push_done = (state == chip_pkg::done);

endmodule

// File: src/pkt_tx.sv
// output stage: holds each word on the valid/ready stream and reports acceptance to the push FSM
`timescale 1ns/1ns

module pkt_tx (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	// word link from push FSM
	chip_if.sink                        cif,
	// stream out
	output logic [chip_pkg::word_w-1:0] tx_data,
	output logic                        tx_valid,
	output logic                        tx_last,
	input  logic                        tx_ready
);

	logic xfer;

	// handshake on the stream
	assign xfer     = tx_valid & tx_ready;
	assign cif.done = xfer;

	// --------------------
	// valid flag
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			tx_valid <= 1'b0;
		else if (cif.vld)
			tx_valid <= 1'b1;
		else if (xfer)
			tx_valid <= 1'b0;
	end

	// payload only loads on a new word, so it stays put under back-pressure
	always_ff @(posedge clk_sys) begin
		if (cif.vld) begin
			tx_data <= cif.d;
			tx_last <= cif.last;
		end
	end

endmodule

// File: test/chip_push_props.sv
// concurrent checks on stream hold, fire refusal and end-of-packet interrupt, bound into the top level
`timescale 1ns/1ns

module chip_push_props #(
	parameter int buf_depth = 256,
	parameter int addr_w    = 8
) (
	input logic                        clk_sys,
	input logic                        rst_n,
	input logic                        psel,
	input logic                        penable,
	input logic                        pwrite,
	input logic [addr_w-1:0]           paddr,
	input logic                        fire_bit,
	input logic [chip_pkg::len_w-1:0]  chip_len,
	input logic [$clog2(buf_depth):0]  level,
	input logic                        busy,
	input logic                        fire,
	input logic [chip_pkg::word_w-1:0] tx_data,
	input logic                        tx_valid,
	input logic                        tx_last,
	input logic                        tx_ready,
	input logic                        irq_done
);

	int unsigned hold_fails   = 0;
	int unsigned refuse_fails = 0;
	int unsigned late_fails   = 0;
	int unsigned src_fails    = 0;
	int unsigned end_fails    = 0;
	logic        fire_req;
	logic        fire_bad;

	// fire request while idle, and the two refusal cases
	assign fire_req = psel && penable && pwrite && fire_bit && !busy &&
		(paddr == addr_w'(chip_pkg::ctrl_addr));
	assign fire_bad = (chip_len == '0) || (int'(level) < int'(chip_len));

	a_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
		else begin
			$error("stream word changed while stalled");
			hold_fails++;
		end

	// refused fire never starts a packet
	a_refuse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire_req && fire_bad |-> !fire ##1 !busy ##1 !tx_valid)
		else begin
			$error("refused fire started a packet");
			refuse_fails++;
		end

	// --------------------
	// end of packet
	// --------------------
	a_irq_late: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_valid && tx_ready && tx_last |-> ##2 irq_done)
		else begin
			$error("no irq_done two cycles after the last word");
			late_fails++;
		end

	a_irq_src: assert property (@(posedge clk_sys) disable iff (!rst_n)
		irq_done |-> $past(tx_valid && tx_ready && tx_last, 2))
		else begin
			$error("irq_done without a last word transfer");
			src_fails++;
		end

	a_irq_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		irq_done |=> !irq_done && !busy)
		else begin
			$error("irq_done longer than one cycle or push still busy");
			end_fails++;
		end

endmodule

// File: test/tb_chip_push.sv
// testbench for the chip pusher: loads words over APB, fires packets and scores the stream output
`timescale 1ns/1ns

module tb_chip_push;

	localparam int addr_w    = 8;
	localparam int buf_depth = 256;
	// lengths taken at their test maximum
	localparam int max_cycles = (3 + 4) * 8 + 3 * (3 + 20) * 8 + (3 + 0) * 8 + (3 + 8) * 8 + 2000;

	logic                clk_sys = 1'b0;
	logic                rst_n;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [addr_w-1:0]   paddr;
	logic [15:0]         pwdata;
	logic [15:0]         prdata;
	logic [15:0]         tx_data;
	logic                tx_valid;
	logic                tx_last;
	logic                tx_ready;
	logic                irq_done;

	int unsigned         errors = 0;
	int unsigned         checks = 0;
	int unsigned         cycles = 0;
	logic [31:0]         rnd = 32'hf245;
	logic [15:0]         seq_exp;
	logic [15:0]         buf_model [$];
	logic [16:0]         exp_q [$];
	bit                  random_ready = 1'b0;
	string               test_name = "reset";
	int                  len;

	chip_push_top #(.buf_depth(buf_depth), .addr_w(addr_w)) UUT (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last),
		.tx_ready(tx_ready), .irq_done(irq_done)
	);

	bind chip_push_top chip_push_props #(.buf_depth(buf_depth), .addr_w(addr_w)) u_props (
		.clk_sys(clk_sys), .rst_n(rst_n), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .fire_bit(pwdata[0]),
		.chip_len(chip_len), .level(level), .busy(busy), .fire(fire),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last),
		.tx_ready(tx_ready), .irq_done(irq_done)
	);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int unsigned prop_fails();
		return UUT.u_props.hold_fails + UUT.u_props.refuse_fails + UUT.u_props.late_fails +
			UUT.u_props.src_fails + UUT.u_props.end_fails;
	endfunction

	task automatic report_counts();
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails());
	endtask

	// hang guard
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout in %s: run still going after %0d cycles", test_name, max_cycles);
			report_counts();
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// --------------------
	// APB access
	// --------------------
	task automatic apb_write(input logic [addr_w-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [addr_w-1:0] addr, output logic [15:0] data);
		@(posedge clk_sys);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(negedge clk_sys);
		data = prdata;
		@(posedge clk_sys);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		seq_exp = '0;
		buf_model.delete();
		exp_q.delete();
	endtask

	task automatic load_words(input int n);
		for (int i = 0; i < n; i++) begin
			rnd = xorshift(rnd);
			buf_model.push_back(rnd[15:0]);
			apb_write(addr_w'(chip_pkg::data_addr), rnd[15:0]);
		end
	endtask

	// scores stream words until irq_done closes the packet
	task automatic collect_packet();
		bit seen_irq;
		seen_irq = 1'b0;
		while (!seen_irq) begin
			@(posedge clk_sys);
			if (random_ready) begin
				rnd = xorshift(rnd);
				tx_ready <= rnd[0];
			end
			@(negedge clk_sys);
			if (tx_valid && tx_ready) begin
				assert (exp_q.size() != 0) else begin
					$display("%s: stream sent word %h beyond the packet", test_name, tx_data);
					errors++;
				end
				if (exp_q.size() != 0)
					check_value("stream word", 32'(exp_q.pop_front()), 32'({tx_last, tx_data}));
			end
			seen_irq = irq_done;
		end
		assert (exp_q.size() == 0) else begin
			$display("%s: packet ended with %0d words not sent", test_name, exp_q.size());
			errors++;
		end
	endtask

	task automatic send_packet(input logic [15:0] sync, input int n);
		logic [15:0] stat;
		exp_q.push_back({1'b0, sync});
		exp_q.push_back({1'b0, 16'(n)});
		exp_q.push_back({1'b0, seq_exp});
		for (int i = 0; i < n; i++)
			exp_q.push_back({i == n - 1, buf_model.pop_front()});
		apb_write(addr_w'(chip_pkg::len_addr), 16'(n));
		apb_write(addr_w'(chip_pkg::sync_addr), sync);
		apb_write(addr_w'(chip_pkg::ctrl_addr), 16'h0001);
		collect_packet();
		seq_exp = seq_exp + 1'b1;
		// done set, idle, fill level down by this packet
		apb_read(addr_w'(chip_pkg::status_addr), stat);
		check_value("status after packet", 32'(buf_model.size() * 16 + 2), 32'(stat));
	endtask

	task automatic refuse_fire(input int n);
		logic [15:0] stat;
		apb_write(addr_w'(chip_pkg::len_addr), 16'(n));
		apb_write(addr_w'(chip_pkg::ctrl_addr), 16'h0001);
		apb_read(addr_w'(chip_pkg::status_addr), stat);
		check_value("status after refusal", 32'(buf_model.size() * 16 + 4), 32'(stat));
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tx_ready = 1'b1;
		apply_reset();

		test_name = "single_len4";
		load_words(4);
		send_packet(16'ha5c3, 4);

		// sequence numbers restart from zero
		apply_reset();
		test_name = "backpressure_x3";
		random_ready = 1'b1;
		for (int p = 0; p < 3; p++) begin
			rnd = xorshift(rnd);
			len = int'(rnd % 32'd20) + 1;
			load_words(len);
			rnd = xorshift(rnd);
			send_packet(rnd[31:16], len);
		end
		random_ready = 1'b0;
		@(posedge clk_sys);
		tx_ready <= 1'b1;

		test_name = "refuse_zero_len";
		refuse_fire(0);
		test_name = "refuse_short_fill";
		load_words(3);
		refuse_fire(8);

		report_counts();
		if (errors == 0 && prop_fails() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: vlog.f
src/chip_pkg.sv
src/chip_if.sv
src/apb_regs.sv
src/chip_buf.sv
src/pchip_push.sv
src/pkt_tx.sv
src/chip_push_top.sv
test/chip_push_props.sv
test/tb_chip_push.sv
